// ==== src/psg_defines.svh ====
`ifndef PSG_DEFINES_SVH
`define PSG_DEFINES_SVH

////////////////////
// Sound generators
////////////////////

// Number of PSG instances
`define PSG_COUNT 2

// PSG n sits at base+2n (latch) and base+2n+1 (data)
`define PSG_BASE_PORT 8'hF6

////////////////////
// System ports
////////////////////

`define SYSCTRL_PORT  8'hFB
`define CASSETTE_PORT 8'hFC

////////////////////
// Timing
////////////////////

`define STROBE_SYNC_STAGES 3   // Bus strobe synchronizer depth
`define PWM_BITS           8   // PWM counter width
`define TONE_PRESCALE      16  // sysclk cycles per tone step
`define BEEP_LEVEL         1023

`endif

// ==== src/psg_pkg.sv ====
package psg_pkg;

    ////////////////////
    // Z80 bus
    ////////////////////

    typedef logic [7:0] io_addr_t;   // Low address byte of an I/O cycle
    typedef logic [7:0] bus_data_t;

    ////////////////////
    // PSG
    ////////////////////

    typedef logic [3:0]  psg_reg_addr_t;
    typedef logic [11:0] tone_period_t;   // Half-period in tone steps
    typedef logic [3:0]  amp_t;
    typedef logic [9:0]  chan_level_t;

    // One side of the stereo sum
    typedef logic [13:0] mix_t;

    // Phase of a bus strobe as seen after synchronization
    typedef enum logic [1:0] {
        st_idle,
        st_active,
        st_done
    } strobe_state_t;

endpackage

// ==== src/bus_decoder.sv ====
`timescale 1ns/1ps

`include "psg_defines.svh"

module bus_decoder (
    input  logic                                   sysclk,
    input  logic                                   reset,
    input  psg_pkg::io_addr_t                      bus_a,
    input  psg_pkg::bus_data_t                     bus_d_in,
    input  logic                                   bus_rd_n,
    input  logic                                   bus_wr_n,
    input  logic                                   bus_iorq_n,
    input  logic                                   cassette_in,
    input  psg_pkg::bus_data_t [`PSG_COUNT-1:0]    psg_rddata,
    output logic [`PSG_COUNT-1:0]                  psg_wren,
    output logic                                   a0,
    output psg_pkg::bus_data_t                     wrdata,
    output psg_pkg::bus_data_t                     bus_d_out,
    output logic                                   bus_d_oe,
    output logic                                   cassette_out
);

    import psg_pkg::*;

    localparam int SYNC_N = `STROBE_SYNC_STAGES;

    logic [SYNC_N-1:0]       wr_sync;
    strobe_state_t           wr_state;
    logic                    wr_fall;
    logic                    wr_pulse;
    logic                    dis_regs;
    logic                    dis_psgs;
    logic [`PSG_COUNT-1:0]   sel_psg;
    logic                    sel_sysctrl;
    logic                    sel_cassette;

    ////////////////////
    // Write strobe
    ////////////////////

    // Data is stable while wr_n is low
    always_ff @(posedge sysclk) begin
        if (!bus_wr_n)
            wrdata <= bus_d_in;
    end

    assign wr_fall  = wr_sync[SYNC_N-1] && !wr_sync[SYNC_N-2];
    assign wr_pulse = (wr_state == st_idle) && wr_fall;   // One pulse per strobe

    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            wr_sync  <= '1;
            wr_state <= st_idle;
        end else begin
            wr_sync <= {wr_sync[SYNC_N-2:0], bus_wr_n};
            case (wr_state)
                st_idle:   if (wr_fall) wr_state <= st_active;
                st_active: if (wr_sync[SYNC_N-1] && wr_sync[SYNC_N-2]) wr_state <= st_done;
                default:   wr_state <= st_idle;
            endcase
        end
    end

    ////////////////////
    // Port decoding
    ////////////////////

    for (genvar i = 0; i < `PSG_COUNT; i++) begin : g_sel
        localparam io_addr_t PORT = io_addr_t'(`PSG_BASE_PORT + 2 * i);
        // PSG 0 survives dis_regs, the others do not
        localparam bit IS_FIRST = (i == 0);

        assign sel_psg[i] = !bus_iorq_n && bus_a[7:1] == PORT[7:1] && !dis_psgs &&
                            (IS_FIRST || !dis_regs);
    end

    assign sel_sysctrl  = !bus_iorq_n && bus_a == io_addr_t'(`SYSCTRL_PORT);
    assign sel_cassette = !bus_iorq_n && bus_a == io_addr_t'(`CASSETTE_PORT);

    assign a0       = bus_a[0];
    assign psg_wren = sel_psg & {`PSG_COUNT{wr_pulse}};

    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            dis_regs     <= 1'b0;
            dis_psgs     <= 1'b0;
            cassette_out <= 1'b0;
        end else if (wr_pulse) begin
            if (sel_sysctrl)  {dis_psgs, dis_regs} <= wrdata[1:0];
            if (sel_cassette) cassette_out <= wrdata[0];
        end
    end

    ////////////////////
    // Read data
    ////////////////////

    always_comb begin
        bus_d_out = '0;
        for (int i = 0; i < `PSG_COUNT; i++) begin
            if (sel_psg[i]) bus_d_out = psg_rddata[i];
        end
        if (sel_sysctrl)  bus_d_out = {6'b0, dis_psgs, dis_regs};
        if (sel_cassette) bus_d_out = {7'b0, cassette_in};
    end

    assign bus_d_oe = !bus_rd_n && (|sel_psg || sel_sysctrl || sel_cassette);

endmodule

// ==== src/psg_core.sv ====
`timescale 1ns/1ps

`include "psg_defines.svh"

module psg_core (
    input  logic                  sysclk,
    input  logic                  reset,
    input  logic                  a0,
    input  logic                  wren,
    input  psg_pkg::bus_data_t    wrdata,
    output psg_pkg::bus_data_t    rddata,
    output psg_pkg::chan_level_t  ch_a,
    output psg_pkg::chan_level_t  ch_b,
    output psg_pkg::chan_level_t  ch_c
);

    import psg_pkg::*;

    localparam int PRE_W = $clog2(`TONE_PRESCALE);

    psg_reg_addr_t   reg_addr;
    tone_period_t    period [3];
    tone_period_t    tone_cnt [3];
    logic [2:0]      tone;
    logic [7:0]      mixer;          // Low 3 bits disable tones
    amp_t            amp [3];
    chan_level_t     level [3];
    logic [PRE_W-1:0] pre_cnt;
    logic            step;

    ////////////////////
    // Registers
    ////////////////////

    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            reg_addr <= '0;
            mixer    <= '0;
            for (int i = 0; i < 3; i++) begin
                period[i] <= '0;
                amp[i]    <= '0;
            end
        end else if (wren) begin
            if (!a0) begin
                reg_addr <= wrdata[3:0];    // Address latch
            end else begin
                case (reg_addr)
                    4'd0:    period[0][7:0]  <= wrdata;
                    4'd1:    period[0][11:8] <= wrdata[3:0];
                    4'd2:    period[1][7:0]  <= wrdata;
                    4'd3:    period[1][11:8] <= wrdata[3:0];
                    4'd4:    period[2][7:0]  <= wrdata;
                    4'd5:    period[2][11:8] <= wrdata[3:0];
                    4'd7:    mixer           <= wrdata;
                    4'd8:    amp[0]          <= wrdata[3:0];
                    4'd9:    amp[1]          <= wrdata[3:0];
                    4'd10:   amp[2]          <= wrdata[3:0];
                    default: ;
                endcase
            end
        end
    end

    // Unused bits and missing registers read as 0
    always_comb begin
        case (reg_addr)
            4'd0:    rddata = period[0][7:0];
            4'd1:    rddata = {4'b0, period[0][11:8]};
            4'd2:    rddata = period[1][7:0];
            4'd3:    rddata = {4'b0, period[1][11:8]};
            4'd4:    rddata = period[2][7:0];
            4'd5:    rddata = {4'b0, period[2][11:8]};
            4'd7:    rddata = mixer;
            4'd8:    rddata = {4'b0, amp[0]};
            4'd9:    rddata = {4'b0, amp[1]};
            4'd10:   rddata = {4'b0, amp[2]};
            default: rddata = '0;
        endcase
    end

    ////////////////////
    // Tone generators
    ////////////////////

    assign step = (pre_cnt == PRE_W'(`TONE_PRESCALE - 1));

    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            pre_cnt <= '0;
            tone    <= '0;
            for (int i = 0; i < 3; i++)
                tone_cnt[i] <= '0;
        end else begin
            pre_cnt <= step ? '0 : pre_cnt + 1'b1;
            if (step) begin
                for (int i = 0; i < 3; i++) begin
                    // >= also catches a period lowered mid-count
                    if (tone_cnt[i] >= period[i]) begin
                        tone_cnt[i] <= '0;
                        tone[i]     <= ~tone[i];
                    end else begin
                        tone_cnt[i] <= tone_cnt[i] + 12'd1;
                    end
                end
            end
        end
    end

    // Amplitude stretched to 10 bits
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            level[i] = (tone[i] || mixer[i]) ? {amp[i], amp[i], amp[i][3:2]} : '0;
        end
    end

    assign ch_a = level[0];
    assign ch_b = level[1];
    assign ch_c = level[2];

endmodule

// ==== src/stereo_mixer.sv ====
`timescale 1ns/1ps

`include "psg_defines.svh"

module stereo_mixer (
    input  psg_pkg::chan_level_t [3*`PSG_COUNT-1:0]  ch_levels,
    input  logic                                     beep,
    output psg_pkg::mix_t                            mix_l,
    output psg_pkg::mix_t                            mix_r
);

    import psg_pkg::*;

    mix_t beep_level;

    assign beep_level = beep ? mix_t'(`BEEP_LEVEL) : '0;

    ////////////////////
    // Weighted sum
    ////////////////////

    // Channel A leans left, C leans right, B sits in the middle
    always_comb begin
        mix_l = beep_level;
        mix_r = beep_level;
        for (int i = 0; i < `PSG_COUNT; i++) begin
            mix_l = mix_l + (mix_t'(ch_levels[3*i])   << 1)
                          + (mix_t'(ch_levels[3*i+1]) << 1)
                          +  mix_t'(ch_levels[3*i+2]);
            mix_r = mix_r +  mix_t'(ch_levels[3*i])
                          + (mix_t'(ch_levels[3*i+1]) << 1)
                          + (mix_t'(ch_levels[3*i+2]) << 1);
        end
    end

endmodule

// ==== src/pwm_dac.sv ====
`timescale 1ns/1ps

`include "psg_defines.svh"

module pwm_dac (
    input  logic           sysclk,
    input  logic           reset,
    input  psg_pkg::mix_t  mix_l,
    input  psg_pkg::mix_t  mix_r,
    output logic           audio_l,
    output logic           audio_r
);

    logic [`PWM_BITS-1:0] pwm_cnt;
    logic [`PWM_BITS-1:0] duty_l;
    logic [`PWM_BITS-1:0] duty_r;

    ////////////////////
    // Counter and reload
    ////////////////////

    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            pwm_cnt <= '0;
            duty_l  <= '0;
            duty_r  <= '0;
        end else begin
            pwm_cnt <= pwm_cnt + 1'b1;
            if (pwm_cnt == '1) begin    // New sample at wrap
                duty_l <= mix_l[$bits(mix_l)-1 -: `PWM_BITS];
                duty_r <= mix_r[$bits(mix_r)-1 -: `PWM_BITS];
            end
        end
    end

    assign audio_l = pwm_cnt < duty_l;
    assign audio_r = pwm_cnt < duty_r;

endmodule

// ==== src/sound_top.sv ====
`timescale 1ns/1ps

`include "psg_defines.svh"

module sound_top (
    input  logic                sysclk,
    input  logic                reset,
    input  psg_pkg::io_addr_t   bus_a,
    input  psg_pkg::bus_data_t  bus_d_in,
    input  logic                bus_rd_n,
    input  logic                bus_wr_n,
    input  logic                bus_iorq_n,
    input  logic                cassette_in,
    output psg_pkg::bus_data_t  bus_d_out,
    output logic                bus_d_oe,
    output logic                cassette_out,
    output logic                audio_l,
    output logic                audio_r
);

    import psg_pkg::*;

    logic [`PSG_COUNT-1:0]                psg_wren;
    logic                                 a0;
    bus_data_t                            wrdata;
    bus_data_t [`PSG_COUNT-1:0]           psg_rddata;
    chan_level_t [3*`PSG_COUNT-1:0]       ch_levels;   // a, b, c per PSG
    mix_t                                 mix_l;
    mix_t                                 mix_r;

    bus_decoder i_bus_decoder (
        .sysclk       (sysclk),
        .reset        (reset),
        .bus_a        (bus_a),
        .bus_d_in     (bus_d_in),
        .bus_rd_n     (bus_rd_n),
        .bus_wr_n     (bus_wr_n),
        .bus_iorq_n   (bus_iorq_n),
        .cassette_in  (cassette_in),
        .psg_rddata   (psg_rddata),
        .psg_wren     (psg_wren),
        .a0           (a0),
        .wrdata       (wrdata),
        .bus_d_out    (bus_d_out),
        .bus_d_oe     (bus_d_oe),
        .cassette_out (cassette_out)
    );

    ////////////////////
    // Sound generators
    ////////////////////

    for (genvar i = 0; i < `PSG_COUNT; i++) begin : g_psg
        psg_core i_psg_core (
            .sysclk (sysclk),
            .reset  (reset),
            .a0     (a0),
            .wren   (psg_wren[i]),
            .wrdata (wrdata),
            .rddata (psg_rddata[i]),
            .ch_a   (ch_levels[3*i]),
            .ch_b   (ch_levels[3*i+1]),
            .ch_c   (ch_levels[3*i+2])
        );
    end

    stereo_mixer i_stereo_mixer (
        .ch_levels (ch_levels),
        .beep      (cassette_out),
        .mix_l     (mix_l),
        .mix_r     (mix_r)
    );

    pwm_dac i_pwm_dac (
        .sysclk  (sysclk),
        .reset   (reset),
        .mix_l   (mix_l),
        .mix_r   (mix_r),
        .audio_l (audio_l),
        .audio_r (audio_r)
    );

endmodule

// ==== tb/sound_properties.sv ====
`timescale 1ns/1ps

module sound_properties (
    input logic sysclk,
    input logic reset,
    input logic bus_rd_n,
    input logic bus_iorq_n,
    input logic bus_d_oe,
    input logic cassette_out,
    input logic audio_l,
    input logic audio_r
);

    // Data bus only driven inside a read I/O cycle
    assert property (@(posedge sysclk) disable iff (reset)
        bus_d_oe |-> (!bus_rd_n && !bus_iorq_n))
        else $error("bus_d_oe high outside an I/O read cycle");

    assert property (@(posedge sysclk) reset |-> (!audio_l && !audio_r))
        else $error("audio outputs active during reset");

    assert property (@(posedge sysclk) reset |-> !cassette_out)
        else $error("cassette_out high during reset");

endmodule

bind sound_top sound_properties i_sound_properties (
    .sysclk       (sysclk),
    .reset        (reset),
    .bus_rd_n     (bus_rd_n),
    .bus_iorq_n   (bus_iorq_n),
    .bus_d_oe     (bus_d_oe),
    .cassette_out (cassette_out),
    .audio_l      (audio_l),
    .audio_r      (audio_r)
);

// ==== tb/tb_sound_top.sv ====
`timescale 1ns/1ps

`include "psg_defines.svh"

module tb_sound_top;

    import psg_pkg::*;

    localparam int STROBE_CYCLES = 4;
    localparam int PWM_PERIOD = 1 << `PWM_BITS;

    logic sysclk;
    logic reset;
    io_addr_t bus_a;
    bus_data_t bus_d_in;
    logic bus_rd_n;
    logic bus_wr_n;
    logic bus_iorq_n;
    logic cassette_in;
    bus_data_t bus_d_out;
    logic bus_d_oe;
    logic cassette_out;
    logic audio_l;
    logic audio_r;

    integer seed;
    bus_data_t model_regs [`PSG_COUNT][16];   // Stored bits, already masked
    bit model_dis_regs;
    bit model_dis_psgs;
    bit model_cassette;
    int test_errors;
    int errors;
    int tests_run;
    int tests_failed;
    bus_data_t got;
    bus_data_t rnd;
    bit answered;
    int idx;
    int high_l;
    int high_r;

    sound_top i_sound_top (
        .sysclk       (sysclk),
        .reset        (reset),
        .bus_a        (bus_a),
        .bus_d_in     (bus_d_in),
        .bus_rd_n     (bus_rd_n),
        .bus_wr_n     (bus_wr_n),
        .bus_iorq_n   (bus_iorq_n),
        .cassette_in  (cassette_in),
        .bus_d_out    (bus_d_out),
        .bus_d_oe     (bus_d_oe),
        .cassette_out (cassette_out),
        .audio_l      (audio_l),
        .audio_r      (audio_r)
    );

    initial begin
        sysclk = 1'b0;
        forever #20 sysclk = ~sysclk;
    end

    ////////////////////
    // Reporting
    ////////////////////

    task automatic report_mismatch(input string name, input int expected, input int actual);
        $display("CHECK FAILED at %0t ns: %s expected 0x%0h, got 0x%0h",
                 $time, name, expected, actual);
        test_errors++;
    endtask

    task automatic report_problem(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        test_errors++;
    endtask

    task automatic close_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("PASS  %s", name);
        end else begin
            $display("FAIL  %s (%0d errors)", name, test_errors);
            tests_failed++;
        end
        errors += test_errors;
        test_errors = 0;
    endtask

    ////////////////////
    // Bus cycles
    ////////////////////

    function automatic bus_data_t rand_byte();
        return bus_data_t'($random(seed));
    endfunction

    task automatic wait_cycles(input int n);
        for (int i = 0; i < n; i++)
            @(negedge sysclk);
    endtask

    // Strobe held 4 cycles, then enough idle time for the strobe FSM to rearm
    task automatic bus_write(input io_addr_t addr, input bus_data_t data);
        @(negedge sysclk);
        bus_a      = addr;
        bus_d_in   = data;
        bus_iorq_n = 1'b0;
        bus_wr_n   = 1'b0;
        wait_cycles(STROBE_CYCLES);
        bus_wr_n   = 1'b1;
        bus_iorq_n = 1'b1;
        wait_cycles(6);
        if (addr == io_addr_t'(`SYSCTRL_PORT))
            {model_dis_psgs, model_dis_regs} = data[1:0];
        if (addr == io_addr_t'(`CASSETTE_PORT))
            model_cassette = data[0];
    endtask

    // Polls bus_d_oe for the length of the strobe
    // ack stays 0 when no port answers
    task automatic bus_read(input io_addr_t addr, output bus_data_t data, output bit ack);
        @(negedge sysclk);
        bus_a      = addr;
        bus_iorq_n = 1'b0;
        bus_rd_n   = 1'b0;
        ack        = 1'b0;
        data       = '0;
        for (int i = 0; i < STROBE_CYCLES; i++) begin
            @(negedge sysclk);
            if (bus_d_oe) begin
                ack  = 1'b1;
                data = bus_d_out;
            end
        end
        bus_rd_n   = 1'b1;
        bus_iorq_n = 1'b1;
        wait_cycles(2);
    endtask

    ////////////////////
    // PSG model
    ////////////////////

    function automatic io_addr_t psg_port(input int p, input int data_port);
        return io_addr_t'(`PSG_BASE_PORT + 2 * p + data_port);
    endfunction

    function automatic bus_data_t reg_mask(input int r);
        case (r)
            0, 2, 4, 7:        return 8'hFF;
            1, 3, 5, 8, 9, 10: return 8'h0F;
            default:           return 8'h00;
        endcase
    endfunction

    task automatic psg_write(input int p, input int r, input bus_data_t data);
        bus_write(psg_port(p, 0), bus_data_t'(r));
        bus_write(psg_port(p, 1), data);
        model_regs[p][r] = data & reg_mask(r);
    endtask

    task automatic psg_read(input int p, input int r, output bus_data_t data, output bit ack);
        bus_write(psg_port(p, 0), bus_data_t'(r));
        bus_read(psg_port(p, 1), data, ack);
    endtask

    // Port $FB readback and which PSG ports answer under the current disable bits
    task automatic check_disable_bits();
        bit expect_ack;
        bus_read(io_addr_t'(`SYSCTRL_PORT), got, answered);
        if (!answered) report_problem("no bus_d_oe on read of port FB");
        if (got !== {6'b0, model_dis_psgs, model_dis_regs})
            report_mismatch("bus_d_out (FB)", {model_dis_psgs, model_dis_regs}, got);
        for (int p = 0; p < `PSG_COUNT; p++) begin
            for (int a = 0; a < 2; a++) begin
                expect_ack = !model_dis_psgs && (p == 0 || !model_dis_regs);
                bus_read(psg_port(p, a), got, answered);
                if (answered != expect_ack)
                    report_problem($sformatf("PSG %0d port %0d %s", p, a,
                                   expect_ack ? "did not answer" : "answered while disabled"));
            end
        end
    endtask

    // Amplitude nibble, again, then its top two bits
    function automatic int level_of(input bus_data_t amp_reg);
        logic [3:0] a;
        a = amp_reg[3:0];
        return int'({a, a, a[3:2]});
    endfunction

    // Valid only while every tone is disabled in register 7
    function automatic int expected_mix(input bit right);
        int sum;
        int a;
        int b;
        int c;
        sum = model_cassette ? `BEEP_LEVEL : 0;
        for (int p = 0; p < `PSG_COUNT; p++) begin
            a = level_of(model_regs[p][8]);
            b = level_of(model_regs[p][9]);
            c = level_of(model_regs[p][10]);
            sum += right ? (a + 2 * b + 2 * c) : (2 * a + 2 * b + c);
        end
        return sum;
    endfunction

    // Settle over two PWM frames, then count one full frame
    task automatic measure_audio(output int cnt_l, output int cnt_r);
        wait_cycles(2 * PWM_PERIOD);
        cnt_l = 0;
        cnt_r = 0;
        for (int i = 0; i < PWM_PERIOD; i++) begin
            @(negedge sysclk);
            if (audio_l) cnt_l++;
            if (audio_r) cnt_r++;
        end
    endtask

    task automatic check_audio();
        measure_audio(high_l, high_r);
        if (high_l != (expected_mix(1'b0) >> 6))
            report_mismatch("audio_l high cycles", expected_mix(1'b0) >> 6, high_l);
        if (high_r != (expected_mix(1'b1) >> 6))
            report_mismatch("audio_r high cycles", expected_mix(1'b1) >> 6, high_r);
    endtask

    ////////////////////
    // Test sequence
    ////////////////////

    initial begin
        seed        = 84250;
        reset       = 1'b1;
        bus_a       = '0;
        bus_d_in    = '0;
        bus_rd_n    = 1'b1;
        bus_wr_n    = 1'b1;
        bus_iorq_n  = 1'b1;
        cassette_in = 1'b0;
        test_errors = 0;
        errors      = 0;
        tests_run   = 0;
        tests_failed = 0;
        model_dis_regs = 1'b0;
        model_dis_psgs = 1'b0;
        model_cassette = 1'b0;
        for (int p = 0; p < `PSG_COUNT; p++)
            for (int r = 0; r < 16; r++)
                model_regs[p][r] = '0;
        wait_cycles(10);
        reset = 1'b0;
        wait_cycles(4);

        // Reset values
        rnd = rand_byte();
        cassette_in = rnd[0];
        bus_read(io_addr_t'(`SYSCTRL_PORT), got, answered);
        if (!answered) report_problem("no bus_d_oe on read of port FB");
        if (got !== 8'h00) report_mismatch("bus_d_out (FB)", 0, got);
        // Both levels of the cassette input
        for (int k = 0; k < 2; k++) begin
            bus_read(io_addr_t'(`CASSETTE_PORT), got, answered);
            if (!answered) report_problem("no bus_d_oe on read of port FC");
            if (got !== {7'b0, cassette_in})
                report_mismatch("bus_d_out (FC)", cassette_in, got);
            cassette_in = !cassette_in;
        end
        if (cassette_out !== 1'b0) report_mismatch("cassette_out", 0, cassette_out);
        close_test("reset values");

        // Register readback
        for (int p = 0; p < `PSG_COUNT; p++) begin
            for (int n = 0; n < 12; n++) begin
                rnd = rand_byte();
                idx = int'(rnd[3:0]);
                psg_write(p, idx, rand_byte());
                psg_read(p, idx, got, answered);
                if (!answered)
                    report_problem($sformatf("PSG %0d register %0d did not answer", p, idx));
                else if (got !== model_regs[p][idx])
                    report_mismatch($sformatf("bus_d_out (PSG %0d reg %0d)", p, idx),
                                    model_regs[p][idx], got);
            end
        end
        close_test("register readback");

        // Disable bits
        bus_write(io_addr_t'(`SYSCTRL_PORT), 8'h01);
        check_disable_bits();
        bus_write(io_addr_t'(`SYSCTRL_PORT), 8'h02);
        check_disable_bits();
        bus_write(io_addr_t'(`SYSCTRL_PORT), 8'h00);
        check_disable_bits();
        close_test("disable bits");

        // Static mix with every tone disabled
        for (int round = 0; round < 3; round++) begin
            for (int p = 0; p < `PSG_COUNT; p++) begin
                psg_write(p, 7, rand_byte() | 8'h07);
                for (int c = 0; c < 3; c++)
                    psg_write(p, 8 + c, rand_byte());
            end
            check_audio();
        end
        close_test("static audio mix");

        // Beep on top of the last mix
        bus_write(io_addr_t'(`CASSETTE_PORT), 8'h01);
        if (cassette_out !== 1'b1) report_mismatch("cassette_out", 1, cassette_out);
        check_audio();
        bus_write(io_addr_t'(`CASSETTE_PORT), 8'h00);
        if (cassette_out !== 1'b0) report_mismatch("cassette_out", 0, cassette_out);
        check_audio();
        close_test("beep");

        $display("Tests run: %0d, tests failed: %0d, errors: %0d", tests_run, tests_failed,
                 errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+src
src/psg_pkg.sv
src/bus_decoder.sv
src/psg_core.sv
src/stereo_mixer.sv
src/pwm_dac.sv
src/sound_top.sv
tb/sound_properties.sv
tb/tb_sound_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the sound_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f --top-module tb_sound_top -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
    exit 1
fi

if ! grep -q "Testbench passed" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi

exit 0
